// ==== dcache_lite.f ====
source/dcache_pkg.sv
source/dcache_ifs.sv
source/dcache_bank.sv
source/dcache_data_block.sv
source/dcache_tag_store.sv
source/dcache_refill_counter.sv
source/dcache_controller.sv
source/dcache_top.sv
verification/dcache_mem_slave.sv
verification/dcache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile with Verilator and run, pass only if the pass line shows up
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module dcache_tb -f dcache_lite.f -o dcache_sim \
    && ./obj_dir/dcache_sim | tee /dev/stderr | grep -qF "** PASS **" \
    && { echo "Simulation passed"; exit 0; } \
    || { echo "Simulation failed"; exit 1; }

// ==== source/dcache_bank.sv ====
`default_nettype none

module dcache_bank (
    input  wire                    clk_i,
    // Write port
    input  wire                    wr_en_i,
    input  dcache_pkg::byte_sel_t  wr_byte_sel_i,
    input  dcache_pkg::index_t     wr_index_i,
    input  dcache_pkg::data_t      wr_data_i,
    // Read port
    input  wire                    rd_en_i,
    input  dcache_pkg::index_t     rd_index_i,
    output dcache_pkg::data_t      rd_data_o
);

    // One word of every line lives in this bank
    dcache_pkg::data_t mem [dcache_pkg::LINE_COUNT];

    // --------------------
    // Byte-wise write
    // --------------------

    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            for (int b = 0; b < dcache_pkg::DATA_W / 8; b++) begin
                // Only the enabled bytes change, the rest keep their value
                if (wr_byte_sel_i[b]) begin
                    mem[wr_index_i][b*8 +: 8] <= wr_data_i[b*8 +: 8];
                end
            end
        end
    end

    // --------------------
    // Registered read
    // --------------------

    // The output holds while the bank is not selected, so idle banks do not toggle
    always_ff @(posedge clk_i) begin
        if (rd_en_i) begin
            rd_data_o <= mem[rd_index_i];
        end
    end

endmodule : dcache_bank

`default_nettype wire

// ==== source/dcache_controller.sv ====
`default_nettype none

module dcache_controller (
    input  wire                   clk_i,
    input  wire                   arst_n_i,
    dcache_tag_if.ctrl            tag,
    dcache_data_if.ctrl           data,
    // Processor side as a Wishbone classic slave
    input  wire                   cpu_cyc_i,
    input  wire                   cpu_stb_i,
    input  wire                   cpu_we_i,
    input  dcache_pkg::addr_t     cpu_adr_i,
    input  dcache_pkg::byte_sel_t cpu_sel_i,
    input  dcache_pkg::data_t     cpu_dat_i,
    output logic                  cpu_ack_o,
    output dcache_pkg::data_t     cpu_dat_o,
    // Memory side as a Wishbone classic master
    output logic                  mem_cyc_o,
    output logic                  mem_stb_o,
    output logic                  mem_we_o,
    output dcache_pkg::addr_t     mem_adr_o,
    output dcache_pkg::byte_sel_t mem_sel_o,
    output dcache_pkg::data_t     mem_dat_o,
    input  wire                   mem_ack_i,
    input  dcache_pkg::data_t     mem_dat_i,
    // Refill word counter
    output logic                  refill_start_o,
    output logic                  refill_advance_o,
    input  dcache_pkg::bank_sel_t refill_word_i,
    input  wire                   refill_last_i
);

    // --------------------
    // Address split
    // --------------------

    // The master holds the address steady, so these fields last the whole request
    dcache_pkg::tag_t      req_tag;
    dcache_pkg::index_t    req_index;
    dcache_pkg::bank_sel_t req_bank;

    assign req_tag   = cpu_adr_i[dcache_pkg::ADDR_W-1 -: dcache_pkg::TAG_W];
    assign req_index = cpu_adr_i[dcache_pkg::OFFSET_W + dcache_pkg::BANK_SEL_W +:
                                 dcache_pkg::INDEX_W];
    assign req_bank  = cpu_adr_i[dcache_pkg::OFFSET_W +: dcache_pkg::BANK_SEL_W];

    // --------------------
    // State register
    // --------------------

    dcache_pkg::ctrl_state_t state_q, state_d;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= dcache_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // --------------------
    // Next state and outputs
    // --------------------

    always_comb begin
        state_d          = state_q;
        cpu_ack_o        = 1'b0;
        mem_cyc_o        = 1'b0;
        mem_stb_o        = 1'b0;
        mem_we_o         = 1'b0;
        mem_adr_o        = cpu_adr_i;
        mem_sel_o        = cpu_sel_i;
        refill_start_o   = 1'b0;
        refill_advance_o = 1'b0;
        tag.lookup_en    = 1'b0;
        tag.fill_en      = 1'b0;
        data.rd_en       = 1'b0;
        data.wr_en       = 1'b0;
        data.wr_bank     = req_bank;
        data.wr_byte_sel = cpu_sel_i;
        data.wr_data     = cpu_dat_i;

        case (state_q)
            dcache_pkg::IDLE: begin
                // Tag and data are read together, both answer in LOOKUP
                if (cpu_cyc_i && cpu_stb_i) begin
                    tag.lookup_en = 1'b1;
                    data.rd_en    = 1'b1;
                    state_d       = dcache_pkg::LOOKUP;
                end
            end
            dcache_pkg::LOOKUP: begin
                if (cpu_we_i) begin
                    state_d = dcache_pkg::WRITE_MEM;
                end else if (tag.hit) begin
                    cpu_ack_o = 1'b1;
                    state_d   = dcache_pkg::IDLE;
                end else begin
                    refill_start_o = 1'b1;
                    state_d        = dcache_pkg::REFILL;
                end
            end
            dcache_pkg::REFILL: begin
                // Each word is a single read and the words walk up from the line base
                mem_cyc_o = 1'b1;
                mem_stb_o = 1'b1;
                mem_adr_o = {req_tag, req_index, refill_word_i,
                             {dcache_pkg::OFFSET_W{1'b0}}};
                mem_sel_o = '1;
                data.wr_bank     = refill_word_i;
                data.wr_byte_sel = '1;
                data.wr_data     = mem_dat_i;
                if (mem_ack_i) begin
                    data.wr_en       = 1'b1;
                    refill_advance_o = 1'b1;
                    if (refill_last_i) begin
                        tag.fill_en = 1'b1;
                        state_d     = dcache_pkg::REREAD;
                    end
                end
            end
            dcache_pkg::REREAD: begin
                // Line is complete now, a second lookup hits and answers
                tag.lookup_en = 1'b1;
                data.rd_en    = 1'b1;
                state_d       = dcache_pkg::LOOKUP;
            end
            dcache_pkg::WRITE_MEM: begin
                mem_cyc_o = 1'b1;
                mem_stb_o = 1'b1;
                mem_we_o  = 1'b1;
                if (mem_ack_i) begin
                    // Write hit updates the cached bytes on the same edge
                    data.wr_en = tag.hit;
                    state_d    = dcache_pkg::RESPOND;
                end
            end
            dcache_pkg::RESPOND: begin
                cpu_ack_o = 1'b1;
                state_d   = dcache_pkg::IDLE;
            end
            default: begin
                state_d = dcache_pkg::IDLE;
            end
        endcase
    end

    // Index and tag never change within one request
    assign data.wr_index    = req_index;
    assign data.rd_index    = req_index;
    assign data.rd_bank     = req_bank;
    assign tag.lookup_index = req_index;
    assign tag.lookup_tag   = req_tag;
    assign tag.fill_index   = req_index;
    assign tag.fill_tag     = req_tag;

    assign cpu_dat_o = data.rd_data;
    assign mem_dat_o = cpu_dat_i;

endmodule : dcache_controller

`default_nettype wire

// ==== source/dcache_data_block.sv ====
`default_nettype none

module dcache_data_block (
    input wire     clk_i,
    dcache_data_if.block data
);

    // --------------------
    // Bank decode
    // --------------------

    logic [dcache_pkg::BANK_COUNT-1:0] wr_bank_en;
    logic [dcache_pkg::BANK_COUNT-1:0] rd_bank_en;

    // One-hot enables let a single bank be written or read per access
    always_comb begin
        wr_bank_en = '0;
        rd_bank_en = '0;
        for (int i = 0; i < dcache_pkg::BANK_COUNT; i++) begin
            if (data.wr_bank == dcache_pkg::bank_sel_t'(i)) begin
                wr_bank_en[i] = 1'b1;
            end
            if (data.rd_bank == dcache_pkg::bank_sel_t'(i)) begin
                rd_bank_en[i] = 1'b1;
            end
        end
    end

    // --------------------
    // Banks
    // --------------------

    dcache_pkg::data_t bank_rd_data [dcache_pkg::BANK_COUNT];

    for (genvar g = 0; g < dcache_pkg::BANK_COUNT; g++) begin : g_bank
        dcache_bank u_bank (
            .clk_i         (clk_i),
            .wr_en_i       (data.wr_en & wr_bank_en[g]),
            .wr_byte_sel_i (data.wr_byte_sel),
            .wr_index_i    (data.wr_index),
            .wr_data_i     (data.wr_data),
            .rd_en_i       (data.rd_en & rd_bank_en[g]),
            .rd_index_i    (data.rd_index),
            .rd_data_o     (bank_rd_data[g])
        );
    end

    // --------------------
    // Output select
    // --------------------

    // Bank data arrives a cycle late, so the select is delayed to match
    dcache_pkg::bank_sel_t rd_bank_q;

    always_ff @(posedge clk_i) begin
        if (data.rd_en) begin
            rd_bank_q <= data.rd_bank;
        end
    end

    assign data.rd_data = bank_rd_data[rd_bank_q];

endmodule : dcache_data_block

`default_nettype wire

// ==== source/dcache_ifs.sv ====
`default_nettype none

// The controller writes and reads the data block through one port each
interface dcache_data_if;
    dcache_pkg::byte_sel_t wr_byte_sel;
    dcache_pkg::bank_sel_t wr_bank;
    dcache_pkg::index_t    wr_index;
    logic                  wr_en;
    dcache_pkg::data_t     wr_data;
    dcache_pkg::bank_sel_t rd_bank;
    dcache_pkg::index_t    rd_index;
    logic                  rd_en;
    // Valid one cycle after the edge where rd_en is high
    dcache_pkg::data_t     rd_data;

    modport ctrl (output wr_byte_sel, wr_bank, wr_index, wr_en, wr_data,
                  output rd_bank, rd_index, rd_en, input rd_data);
    modport block (input wr_byte_sel, wr_bank, wr_index, wr_en, wr_data,
                   input rd_bank, rd_index, rd_en, output rd_data);
endinterface : dcache_data_if

// The controller looks up and fills the tag store over this bus
interface dcache_tag_if;
    logic               lookup_en;
    dcache_pkg::index_t lookup_index;
    dcache_pkg::tag_t   lookup_tag;
    logic               fill_en;
    dcache_pkg::index_t fill_index;
    dcache_pkg::tag_t   fill_tag;
    // Valid in the cycle after the lookup edge
    logic               hit;

    modport ctrl (output lookup_en, lookup_index, lookup_tag,
                  output fill_en, fill_index, fill_tag, input hit);
    modport store (input lookup_en, lookup_index, lookup_tag,
                   input fill_en, fill_index, fill_tag, output hit);
endinterface : dcache_tag_if

`default_nettype wire

// ==== source/dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

    // --------------------
    // Cache geometry
    // --------------------

    // Byte address width on both Wishbone ports
    localparam int ADDR_W = 32;

    // Data word width and also the width of one bank
    localparam int DATA_W = 32;

    // Words per line and also the number of banks
    localparam int BANK_COUNT = 4;

    // Lines in the direct-mapped array
    localparam int LINE_COUNT = 64;

    // The address splits, low to high, into byte in word, word in line, line index and tag
    localparam int OFFSET_W   = 2;
    localparam int BANK_SEL_W = 2;
    localparam int INDEX_W    = 6;
    localparam int TAG_W      = ADDR_W - INDEX_W - BANK_SEL_W - OFFSET_W;

    // --------------------
    // Vector types
    // --------------------

    typedef logic [ADDR_W-1:0]     addr_t;
    typedef logic [DATA_W-1:0]     data_t;
    typedef logic [DATA_W/8-1:0]   byte_sel_t;
    typedef logic [BANK_SEL_W-1:0] bank_sel_t;
    typedef logic [INDEX_W-1:0]    index_t;
    typedef logic [TAG_W-1:0]      tag_t;

    // --------------------
    // Controller FSM
    // --------------------

    // REREAD repeats the lookup once the refilled line is in place
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        REFILL,
        REREAD,
        WRITE_MEM,
        RESPOND
    } ctrl_state_t;

endpackage : dcache_pkg

`default_nettype wire

// ==== source/dcache_refill_counter.sv ====
`default_nettype none

module dcache_refill_counter (
    input  wire                   clk_i,
    input  wire                   arst_n_i,
    input  wire                   start_i,
    input  wire                   advance_i,
    output dcache_pkg::bank_sel_t word_o,
    output logic                  last_o
);

    // Index of the next line word to fetch from memory
    dcache_pkg::bank_sel_t count_q;

    // --------------------
    // Word counter
    // --------------------

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            count_q <= '0;
        end else if (start_i) begin
            count_q <= '0;
        end else if (advance_i) begin
            // Wraps to zero after the last word
            count_q <= count_q + 1'b1;
        end
    end

    assign word_o = count_q;

    // Flags the final word so the FSM needs no compare of its own
    assign last_o = (count_q == dcache_pkg::bank_sel_t'(dcache_pkg::BANK_COUNT - 1));

endmodule : dcache_refill_counter

`default_nettype wire

// ==== source/dcache_tag_store.sv ====
`default_nettype none

module dcache_tag_store (
    input wire    clk_i,
    input wire    arst_n_i,
    dcache_tag_if.store tag
);

    // --------------------
    // Storage
    // --------------------

    // Each line keeps the upper address bits it was filled from
    dcache_pkg::tag_t tags [dcache_pkg::LINE_COUNT];

    logic [dcache_pkg::LINE_COUNT-1:0] valid;

    always_ff @(posedge clk_i) begin
        if (tag.fill_en) begin
            tags[tag.fill_index] <= tag.fill_tag;
        end
    end

    // All lines start invalid, a fill marks its line as present
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid <= '0;
        end else if (tag.fill_en) begin
            valid[tag.fill_index] <= 1'b1;
        end
    end

    // --------------------
    // Hit detection
    // --------------------

    logic hit_q;

    // The registered compare keeps hit until the next lookup
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hit_q <= 1'b0;
        end else if (tag.lookup_en) begin
            hit_q <= valid[tag.lookup_index] &&
                     (tags[tag.lookup_index] == tag.lookup_tag);
        end
    end

    assign tag.hit = hit_q;

endmodule : dcache_tag_store

`default_nettype wire

// ==== source/dcache_top.sv ====
`default_nettype none

module dcache_top (
    input  wire                   clk_i,
    input  wire                   arst_n_i,
    // Processor side as a Wishbone classic slave
    input  wire                   cpu_cyc_i,
    input  wire                   cpu_stb_i,
    input  wire                   cpu_we_i,
    input  dcache_pkg::addr_t     cpu_adr_i,
    input  dcache_pkg::byte_sel_t cpu_sel_i,
    input  dcache_pkg::data_t     cpu_dat_i,
    output logic                  cpu_ack_o,
    output dcache_pkg::data_t     cpu_dat_o,
    // Memory side as a Wishbone classic master
    output logic                  mem_cyc_o,
    output logic                  mem_stb_o,
    output logic                  mem_we_o,
    output dcache_pkg::addr_t     mem_adr_o,
    output dcache_pkg::byte_sel_t mem_sel_o,
    output dcache_pkg::data_t     mem_dat_o,
    input  wire                   mem_ack_i,
    input  dcache_pkg::data_t     mem_dat_i
);

    // --------------------
    // Internal buses
    // --------------------

    dcache_data_if data_bus ();
    dcache_tag_if  tag_bus ();

    logic                  refill_start;
    logic                  refill_advance;
    logic                  refill_last;
    dcache_pkg::bank_sel_t refill_word;

    // --------------------
    // Instances
    // --------------------

    dcache_controller u_controller (
        .clk_i            (clk_i),
        .arst_n_i         (arst_n_i),
        .tag              (tag_bus.ctrl),
        .data             (data_bus.ctrl),
        .cpu_cyc_i        (cpu_cyc_i),
        .cpu_stb_i        (cpu_stb_i),
        .cpu_we_i         (cpu_we_i),
        .cpu_adr_i        (cpu_adr_i),
        .cpu_sel_i        (cpu_sel_i),
        .cpu_dat_i        (cpu_dat_i),
        .cpu_ack_o        (cpu_ack_o),
        .cpu_dat_o        (cpu_dat_o),
        .mem_cyc_o        (mem_cyc_o),
        .mem_stb_o        (mem_stb_o),
        .mem_we_o         (mem_we_o),
        .mem_adr_o        (mem_adr_o),
        .mem_sel_o        (mem_sel_o),
        .mem_dat_o        (mem_dat_o),
        .mem_ack_i        (mem_ack_i),
        .mem_dat_i        (mem_dat_i),
        .refill_start_o   (refill_start),
        .refill_advance_o (refill_advance),
        .refill_word_i    (refill_word),
        .refill_last_i    (refill_last)
    );

    dcache_data_block u_data_block (
        .clk_i (clk_i),
        .data  (data_bus.block)
    );

    dcache_tag_store u_tag_store (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .tag      (tag_bus.store)
    );

    dcache_refill_counter u_refill_counter (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .start_i   (refill_start),
        .advance_i (refill_advance),
        .word_o    (refill_word),
        .last_o    (refill_last)
    );

endmodule : dcache_top

`default_nettype wire

// ==== verification/dcache_mem_slave.sv ====
`default_nettype none

module dcache_mem_slave #(
    parameter int SEED  = 1,
    parameter int WORDS = 1024
) (
    input  wire                   clk_i,
    input  wire                   arst_n_i,
    // Wishbone classic slave driven by the cache memory port
    input  wire                   cyc_i,
    input  wire                   stb_i,
    input  wire                   we_i,
    input  dcache_pkg::addr_t     adr_i,
    input  dcache_pkg::byte_sel_t sel_i,
    input  dcache_pkg::data_t     dat_i,
    output logic                  ack_o,
    output dcache_pkg::data_t     dat_o
);

    localparam int IDX_W = $clog2(WORDS);

    // The testbench copies this backing store once to seed its model
    dcache_pkg::data_t mem [WORDS];

    int          seed;
    int          wait_cnt;
    int          idx;
    logic        armed;
    logic [31:0] rnd;

    // Every word gets a value that depends on its whole word address
    initial begin
        seed = SEED;
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = (dcache_pkg::data_t'(i) * 32'h9E37_79B9) ^ dcache_pkg::data_t'(SEED);
        end
    end

    // --------------------
    // Bus responder
    // --------------------

    // A new request draws 0 to 3 wait cycles before the registered ack
    always @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_o    <= 1'b0;
            dat_o    <= '0;
            armed    = 1'b0;
            wait_cnt = 0;
        end else if (ack_o) begin
            // Ack lasts one cycle, the master then moves to its next word
            ack_o <= 1'b0;
            armed = 1'b0;
        end else if (cyc_i && stb_i) begin
            if (!armed) begin
                rnd      = $random(seed);
                wait_cnt = int'(rnd[1:0]);
                armed    = 1'b1;
            end
            if (wait_cnt == 0) begin
                idx   = int'(adr_i[IDX_W+1:2]);
                ack_o <= 1'b1;
                if (we_i) begin
                    for (int b = 0; b < 4; b++) begin
                        if (sel_i[b]) begin
                            mem[idx][b*8 +: 8] = dat_i[b*8 +: 8];
                        end
                    end
                end else begin
                    dat_o <= mem[idx];
                end
            end else begin
                wait_cnt--;
            end
        end
    end

endmodule : dcache_mem_slave

`default_nettype wire

// ==== verification/dcache_tb.sv ====
`default_nettype none

module dcache_tb;

    localparam int CLK_PERIOD = 40;
    localparam int SEED       = 73076;
    localparam int TXN_COUNT  = 400;
    localparam int MEM_BYTES  = 4096;
    localparam int MEM_WORDS  = MEM_BYTES / 4;
    localparam int TIMEOUT    = TXN_COUNT * 30 * CLK_PERIOD;

    logic                  clk_i;
    logic                  arst_n_i;
    logic                  cpu_cyc_i;
    logic                  cpu_stb_i;
    logic                  cpu_we_i;
    dcache_pkg::addr_t     cpu_adr_i;
    dcache_pkg::byte_sel_t cpu_sel_i;
    dcache_pkg::data_t     cpu_dat_i;
    logic                  cpu_ack_o;
    dcache_pkg::data_t     cpu_dat_o;
    logic                  mem_cyc_o;
    logic                  mem_stb_o;
    logic                  mem_we_o;
    dcache_pkg::addr_t     mem_adr_o;
    dcache_pkg::byte_sel_t mem_sel_o;
    dcache_pkg::data_t     mem_dat_o;
    logic                  mem_ack_i;
    dcache_pkg::data_t     mem_dat_i;

    // Reference model with a flat memory and a direct-mapped tag table
    dcache_pkg::data_t ref_mem   [MEM_WORDS];
    dcache_pkg::tag_t  ref_tag   [dcache_pkg::LINE_COUNT];
    logic              ref_valid [dcache_pkg::LINE_COUNT];

    int seed;

    dcache_top u_dut (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .cpu_cyc_i (cpu_cyc_i),
        .cpu_stb_i (cpu_stb_i),
        .cpu_we_i  (cpu_we_i),
        .cpu_adr_i (cpu_adr_i),
        .cpu_sel_i (cpu_sel_i),
        .cpu_dat_i (cpu_dat_i),
        .cpu_ack_o (cpu_ack_o),
        .cpu_dat_o (cpu_dat_o),
        .mem_cyc_o (mem_cyc_o),
        .mem_stb_o (mem_stb_o),
        .mem_we_o  (mem_we_o),
        .mem_adr_o (mem_adr_o),
        .mem_sel_o (mem_sel_o),
        .mem_dat_o (mem_dat_o),
        .mem_ack_i (mem_ack_i),
        .mem_dat_i (mem_dat_i)
    );

    dcache_mem_slave #(.SEED(SEED), .WORDS(MEM_WORDS)) u_mem (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .cyc_i    (mem_cyc_o),
        .stb_i    (mem_stb_o),
        .we_i     (mem_we_o),
        .adr_i    (mem_adr_o),
        .sel_i    (mem_sel_o),
        .dat_i    (mem_dat_o),
        .ack_o    (mem_ack_i),
        .dat_o    (mem_dat_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // --------------------
    // Checks
    // --------------------

    task automatic stop_on_failure();
        $display("** FAIL **");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_data(input dcache_pkg::data_t got, input dcache_pkg::data_t exp,
                              input string what);
        if (got !== exp) begin
            $display("ERROR at time %0t: %s is %h, expected %h", $time, what, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_addr(input dcache_pkg::addr_t got, input dcache_pkg::addr_t exp,
                              input string what);
        if (got !== exp) begin
            $display("ERROR at time %0t: %s is %h, expected %h", $time, what, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_sel(input dcache_pkg::byte_sel_t got, input dcache_pkg::byte_sel_t exp,
                             input string what);
        if (got !== exp) begin
            $display("ERROR at time %0t: %s is %b, expected %b", $time, what, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("ERROR at time %0t: %s is %b, expected %b", $time, what, got, exp);
            stop_on_failure();
        end
    endtask

    // --------------------
    // One processor access
    // --------------------

    // Drives a request, watches both buses every falling edge until the ack
    task automatic run_access(input logic is_write, input dcache_pkg::addr_t adr,
                              input dcache_pkg::byte_sel_t sel, input dcache_pkg::data_t wdata);
        dcache_pkg::index_t idx;
        dcache_pkg::tag_t   tg;
        dcache_pkg::addr_t  line_base;
        logic               predict_hit;
        logic               mem_seen;
        int                 cycles;
        int                 mem_count;
        int                 last_mem_cycle;
        int                 word;
        idx         = dcache_pkg::index_t'(adr >> (dcache_pkg::OFFSET_W + dcache_pkg::BANK_SEL_W));
        tg          = dcache_pkg::tag_t'(adr >> (dcache_pkg::ADDR_W - dcache_pkg::TAG_W));
        line_base   = adr & ~dcache_pkg::addr_t'(dcache_pkg::BANK_COUNT * 4 - 1);
        word        = int'(adr >> 2);
        predict_hit = ref_valid[idx] && (ref_tag[idx] == tg);
        cycles         = 0;
        mem_count      = 0;
        last_mem_cycle = 0;
        mem_seen       = 1'b0;
        @(negedge clk_i);
        // The previous ack lasted a single cycle
        check_flag(cpu_ack_o, 1'b0, "cpu_ack_o between requests");
        cpu_cyc_i = 1'b1;
        cpu_stb_i = 1'b1;
        cpu_we_i  = is_write;
        cpu_adr_i = adr;
        cpu_sel_i = sel;
        cpu_dat_i = wdata;
        do begin
            @(negedge clk_i);
            cycles++;
            if (mem_cyc_o) begin
                mem_seen = 1'b1;
            end
            if (mem_cyc_o && mem_stb_o && mem_ack_i) begin
                if (is_write) begin
                    check_flag(mem_we_o, 1'b1, "memory write enable");
                    check_addr(mem_adr_o, adr, "memory write address");
                    check_sel(mem_sel_o, sel, "memory write byte selects");
                    check_data(mem_dat_o, wdata, "memory write data");
                end else begin
                    // Refill order is base, base plus 4, plus 8, plus 12
                    check_flag(mem_we_o, 1'b0, "memory write enable during refill");
                    check_addr(mem_adr_o, line_base + dcache_pkg::addr_t'(4 * mem_count),
                               "refill read address");
                end
                mem_count++;
                last_mem_cycle = cycles;
            end
        end while (!cpu_ack_o);
        if (is_write) begin
            check_flag(mem_count == 1, 1'b1, "exactly one memory write per processor write");
            check_flag(cycles == last_mem_cycle + 1, 1'b1, "write ack in the cycle after mem ack");
            for (int b = 0; b < 4; b++) begin
                if (sel[b]) begin
                    ref_mem[word][b*8 +: 8] = wdata[b*8 +: 8];
                end
            end
        end else begin
            check_data(cpu_dat_o, ref_mem[word], "read data");
            check_flag(mem_seen, !predict_hit, "memory activity during read, expected on miss");
            if (predict_hit) begin
                check_flag(cycles == 1, 1'b1, "read hit acked in the cycle after the request");
            end else begin
                check_flag(mem_count == 4, 1'b1, "four refill reads on a read miss");
                check_flag(cycles == last_mem_cycle + 2, 1'b1, "miss ack after the reread cycle");
                // Only a read miss allocates a line
                ref_valid[idx] = 1'b1;
                ref_tag[idx]   = tg;
            end
        end
        cpu_cyc_i = 1'b0;
        cpu_stb_i = 1'b0;
        cpu_we_i  = 1'b0;
    endtask

    // --------------------
    // Main sequence
    // --------------------

    initial begin
        logic [31:0]           rnd;
        logic                  is_write;
        dcache_pkg::addr_t     adr;
        dcache_pkg::byte_sel_t sel;
        dcache_pkg::data_t     wdata;
        seed      = SEED;
        arst_n_i  = 1'b0;
        cpu_cyc_i = 1'b0;
        cpu_stb_i = 1'b0;
        cpu_we_i  = 1'b0;
        cpu_adr_i = '0;
        cpu_sel_i = '0;
        cpu_dat_i = '0;
        repeat (5) @(posedge clk_i);
        @(negedge clk_i);
        arst_n_i = 1'b1;
        check_flag(cpu_ack_o, 1'b0, "cpu_ack_o after reset");
        check_flag(mem_cyc_o, 1'b0, "mem_cyc_o after reset");
        check_flag(mem_stb_o, 1'b0, "mem_stb_o after reset");
        check_flag(mem_we_o, 1'b0, "mem_we_o after reset");
        for (int i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i] = u_mem.mem[i];
        end
        for (int i = 0; i < dcache_pkg::LINE_COUNT; i++) begin
            ref_valid[i] = 1'b0;
        end
        for (int n = 0; n < TXN_COUNT; n++) begin
            rnd      = $random(seed);
            is_write = (rnd % 32'd10) >= 32'd6;
            rnd      = $random(seed);
            // Addresses are word aligned in the 4 KiB window where four tags share each index
            adr      = dcache_pkg::addr_t'({rnd[11:2], 2'b00});
            rnd      = $random(seed);
            sel      = dcache_pkg::byte_sel_t'(32'd1 + (rnd % 32'd15));
            rnd      = $random(seed);
            wdata    = rnd;
            run_access(is_write, adr, sel, wdata);
        end
        $display("** PASS **");
        $finish;
    end

    // The watchdog allows 30 cycles for every transaction
    initial begin
        #(TIMEOUT);
        $display("Timeout: the test did not finish within %0d time units", TIMEOUT);
        stop_on_failure();
    end

endmodule : dcache_tb

`default_nettype wire
